// ==== verilog/cpuPkg.sv ====
package cpuPkg;

  ////////////////////////////////
  // Machine word and registers
  ////////////////////////////////
  typedef logic [15:0] wordT;     // Data, instruction and address
  typedef logic [3:0]  regAddrT;  // R0..R15

  // Opcodes not listed run as no-ops
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    NOR = 4'd3,
    SLL = 4'd4,
    SRL = 4'd5,
    SRA = 4'd6,
    LW  = 4'd8,
    SW  = 4'd9,
    LHB = 4'd10,
    LLB = 4'd11,
    B   = 4'd12,
    HLT = 4'd15
  } opcodeT;

  // Branch condition codes, tested against registered flags
  typedef enum logic [2:0] {
    NEQ    = 3'd0,  // Z clear
    EQ     = 3'd1,  // Z set
    GT     = 3'd2,  // Z and N clear
    LT     = 3'd3,  // N set
    GTE    = 3'd4,
    LTE    = 3'd5,
    OVFL   = 3'd6,  // V set
    UNCOND = 3'd7
  } condT;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

  // Arbiter master index, lower value wins
  typedef enum logic [1:0] {
    LOADER = 2'd0,
    DATA   = 2'd1,
    FETCH  = 2'd2
  } masterT;

  ////////////////////////////////
  // Instruction fields
  ////////////////////////////////
  localparam int opHi    = 15;
  localparam int opLo    = 12;
  localparam int rdHi    = 11;  // Also LW/SW data register
  localparam int rdLo    = 8;
  localparam int rsHi    = 7;   // Also LW/SW base
  localparam int rsLo    = 4;
  localparam int rtHi    = 3;   // Also shamt and memory offset
  localparam int rtLo    = 0;
  localparam int immHi   = 7;
  localparam int immLo   = 0;
  localparam int condHi  = 11;
  localparam int condLo  = 9;
  localparam int brOffHi = 8;
  localparam int brOffLo = 0;

  localparam int memDepth = 256;
  localparam int memAddrW = $clog2(memDepth);  // Low word bits used as address

endpackage

// ==== verilog/memBusIf.sv ====
`timescale 1ns/100ps

// One master port onto the shared memory
interface memBusIf import cpuPkg::*; ();

  logic req;     // Held until gnt
  logic we;
  wordT addr;
  wordT wdata;
  logic gnt;     // Same cycle as req
  wordT rdata;
  logic rvalid;  // One cycle after a granted read

  modport master (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport slave (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

// ==== verilog/unifiedMem.sv ====
`timescale 1ns/100ps

// Program and data share this RAM
module unifiedMem import cpuPkg::*; (
  input  logic clk,
  input  logic memWe,
  input  wordT memAddr,
  input  wordT memWdata,
  output wordT memRdata
);

  wordT mem [memDepth];
  logic [memAddrW-1:0] wordIdx;

  assign wordIdx = memAddr[memAddrW-1:0];  // Upper address bits ignored

  always_ff @(posedge clk) begin
    if (memWe) begin
      mem[wordIdx] <= memWdata;
    end
    memRdata <= mem[wordIdx];  // Old data on a same-cycle write
  end

endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/100ps

module memArbiter import cpuPkg::*; (
  input  logic   clk,
  input  logic   rst,
  memBusIf.slave loader,
  memBusIf.slave data,
  memBusIf.slave fetch,
  output logic   memWe,
  output wordT   memAddr,
  output wordT   memWdata,
  input  wordT   memRdata
);

  masterT sel;
  logic   selValid;
  masterT rdOwner;    // Who gets next cycle's rdata
  logic   rdPending;

  ////////////////////////////////
  // Fixed priority select
  ////////////////////////////////
  always_comb begin
    selValid = loader.req || data.req || fetch.req;
    if (loader.req)
      sel = LOADER;
    else if (data.req)
      sel = DATA;
    else
      sel = FETCH;
  end

  assign loader.gnt = selValid && (sel == LOADER);
  assign data.gnt   = selValid && (sel == DATA);
  assign fetch.gnt  = selValid && (sel == FETCH);

  always_comb begin
    unique case (sel)
      LOADER: begin
        memWe    = selValid && loader.we;
        memAddr  = loader.addr;
        memWdata = loader.wdata;
      end
      DATA: begin
        memWe    = selValid && data.we;
        memAddr  = data.addr;
        memWdata = data.wdata;
      end
      default: begin
        memWe    = selValid && fetch.we;
        memAddr  = fetch.addr;
        memWdata = fetch.wdata;
      end
    endcase
  end

  ////////////////////////////////
  // Read return steering
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      rdPending <= 1'b0;
    end else begin
      rdPending <= selValid && !memWe;  // Granted read
    end
    rdOwner <= sel;
  end

  assign loader.rdata = memRdata;
  assign data.rdata   = memRdata;
  assign fetch.rdata  = memRdata;

  assign loader.rvalid = rdPending && (rdOwner == LOADER);
  assign data.rvalid   = rdPending && (rdOwner == DATA);
  assign fetch.rvalid  = rdPending && (rdOwner == FETCH);

endmodule

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/100ps

module fetchUnit import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  memBusIf.master bus,
  output logic    instrValid,
  output wordT    instr,
  output wordT    instrPc,
  input  logic    take,
  input  logic    redirect,
  input  wordT    target,
  input  logic    halted
);

  logic runEn;     // Low for the cycle after reset
  wordT fetchPc;
  wordT reqPc;     // PC of the word in flight
  logic inFlight;
  logic discard;   // Drop the word requested under a redirect
  logic bufValid;
  wordT bufInstr;
  wordT bufPc;
  logic rxValid;

  assign rxValid = inFlight && bus.rvalid && !discard;

  // Arriving word bypasses the buffer
  assign instrValid = bufValid || rxValid;
  assign instr      = rxValid ? bus.rdata : bufInstr;
  assign instrPc    = rxValid ? reqPc : bufPc;  // Holds last PC once idle

  // Ask for the next word only when the slot will be free
  assign bus.req   = runEn && !halted && (!instrValid || take);
  assign bus.we    = 1'b0;
  assign bus.addr  = fetchPc;
  assign bus.wdata = '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      runEn    <= 1'b0;
      fetchPc  <= '0;
      inFlight <= 1'b0;
      discard  <= 1'b0;
      bufValid <= 1'b0;
      bufPc    <= '0;
    end else begin
      runEn    <= 1'b1;
      inFlight <= bus.req && bus.gnt;
      discard  <= redirect && bus.req && bus.gnt;
      if (redirect)
        fetchPc <= target;
      else if (bus.req && bus.gnt)
        fetchPc <= fetchPc + 16'd1;
      if (redirect || take)
        bufValid <= 1'b0;
      else if (rxValid)
        bufValid <= 1'b1;
      if (rxValid)
        bufPc <= reqPc;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req && bus.gnt) reqPc <= fetchPc;
    if (rxValid) bufInstr <= bus.rdata;
  end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  regAddrT rdAddrA,
  input  regAddrT rdAddrB,
  output wordT    rdDataA,
  output wordT    rdDataB,
  input  logic    wrEn,
  input  regAddrT wrAddr,
  input  wordT    wrData
);

  wordT regs [16];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) regs[i] <= '0;
    end else if (wrEn && (wrAddr != '0)) begin  // R0 never written
      regs[wrAddr] <= wrData;
    end
  end

  // Combinational reads, new value visible next cycle
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// ==== verilog/aluFlags.sv ====
`timescale 1ns/100ps

module aluFlags import cpuPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  opcodeT     op,
  input  wordT       opA,
  input  wordT       opB,
  input  logic [3:0] shamt,
  input  logic       update,   // One per executed ALU op
  output wordT       result,
  input  condT       cond,
  output logic       condMet
);

  flagsT flags;
  logic  ovf;

  ////////////////////////////////
  // Datapath
  ////////////////////////////////
  always_comb begin
    ovf    = 1'b0;
    result = '0;
    case (op)
      ADD: begin
        result = opA + opB;  // Wraps
        ovf    = (opA[15] == opB[15]) && (result[15] != opA[15]);
      end
      SUB: begin
        result = opA - opB;
        ovf    = (opA[15] != opB[15]) && (result[15] != opA[15]);
      end
      AND: result = opA & opB;
      NOR: result = ~(opA | opB);
      SLL: result = opA << shamt;
      SRL: result = opA >> shamt;
      SRA: result = wordT'($signed(opA) >>> shamt);  // Sign fill
      default: result = '0;
    endcase
  end

  ////////////////////////////////
  // Flag register
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (update) begin
      flags.z <= (result == '0);
      if ((op == ADD) || (op == SUB)) begin  // N and V from arithmetic only
        flags.n <= result[15];
        flags.v <= ovf;
      end
    end
  end

  always_comb begin
    unique case (cond)
      NEQ:     condMet = !flags.z;
      EQ:      condMet = flags.z;
      GT:      condMet = !flags.z && !flags.n;
      LT:      condMet = flags.n;
      GTE:     condMet = flags.z || !flags.n;
      LTE:     condMet = flags.z || flags.n;
      OVFL:    condMet = flags.v;
      default: condMet = 1'b1;  // UNCOND
    endcase
  end

endmodule

// ==== verilog/execUnit.sv ====
`timescale 1ns/100ps

module execUnit import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  memBusIf.master bus,
  input  logic    instrValid,
  input  wordT    instr,
  input  wordT    instrPc,
  output logic    take,
  output logic    redirect,
  output wordT    target,
  output logic    halted,
  output logic    commitValid,
  output regAddrT commitAddr,
  output wordT    commitData
);

  typedef enum logic {ldIdle, ldWait} ldStateT;

  opcodeT     op;
  regAddrT    rdAddr;
  regAddrT    rdAddrA;
  regAddrT    rdAddrB;
  wordT       rdDataA;
  wordT       rdDataB;
  logic [7:0] imm;
  wordT       aluResult;
  logic       condMet;
  logic       aluOp;
  logic       wrEn;
  wordT       wrData;
  logic       haltReg;
  logic       active;
  ldStateT    ldState;

  ////////////////////////////////
  // Decode
  ////////////////////////////////
  assign op      = opcodeT'(instr[opHi:opLo]);
  assign rdAddr  = instr[rdHi:rdLo];
  assign imm     = instr[immHi:immLo];
  assign rdAddrA = (op == LHB) ? rdAddr : instr[rsHi:rsLo];  // LHB keeps rd low byte
  assign rdAddrB = (op == SW) ? rdAddr : instr[rtHi:rtLo];   // Store data
  assign aluOp   = (op inside {ADD, SUB, AND, NOR, SLL, SRL, SRA});
  assign active  = instrValid && !haltReg;

  regFile uRegs (.clk, .rst, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
                 .wrEn, .wrAddr(rdAddr), .wrData);

  aluFlags uAlu (.clk, .rst, .op, .opA(rdDataA), .opB(rdDataB),
                 .shamt(instr[rtHi:rtLo]), .update(take && aluOp),
                 .result(aluResult), .cond(condT'(instr[condHi:condLo])), .condMet);

  // Base plus signed 4-bit offset
  assign bus.addr  = rdDataA + {{12{instr[rtHi]}}, instr[rtHi:rtLo]};
  assign bus.wdata = rdDataB;
  assign bus.we    = (op == SW);
  assign bus.req   = active && ((op == SW) || ((op == LW) && (ldState == ldIdle)));

  assign target   = instrPc + 16'd1 + {{7{instr[brOffHi]}}, instr[brOffHi:brOffLo]};
  assign redirect = take && (op == B) && condMet;
  assign halted   = haltReg || (instrValid && (op == HLT));  // Blocks fetch at once

  always_comb begin
    take   = active;     // Single-cycle by default
    wrEn   = active && aluOp;
    wrData = aluResult;
    case (op)
      LLB: begin
        wrEn   = active;
        wrData = {{8{imm[7]}}, imm};
      end
      LHB: begin
        wrEn   = active;
        wrData = {imm, rdDataA[7:0]};
      end
      LW: begin
        take   = active && (ldState == ldWait) && bus.rvalid;
        wrEn   = take;
        wrData = bus.rdata;
      end
      SW:      take = active && bus.gnt;  // Done at the write edge
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      haltReg <= 1'b0;
      ldState <= ldIdle;
    end else begin
      if (take && (op == HLT)) haltReg <= 1'b1;
      if ((ldState == ldIdle) && bus.req && bus.gnt && (op == LW))
        ldState <= ldWait;
      else if ((ldState == ldWait) && bus.rvalid)
        ldState <= ldIdle;
    end
  end

  // Write-back doubles as the commit trace
  assign commitValid = wrEn && (rdAddr != '0);
  assign commitAddr  = rdAddr;
  assign commitData  = wrData;

endmodule

// ==== verilog/cpuTop.sv ====
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    loadEn,
  input  wordT    loadAddr,
  input  wordT    loadData,
  output logic    hlt,
  output wordT    pc,
  output logic    commitValid,
  output regAddrT commitAddr,
  output wordT    commitData
);

  memBusIf loaderBus ();
  memBusIf dataBus ();
  memBusIf fetchBus ();

  logic instrValid;
  wordT instr;
  wordT instrPc;
  logic take;
  logic redirect;
  wordT target;
  logic halted;
  logic memWe;
  wordT memAddr;
  wordT memWdata;
  wordT memRdata;

  // Program load as top-priority writes
  assign loaderBus.req   = loadEn;
  assign loaderBus.we    = 1'b1;
  assign loaderBus.addr  = loadAddr;
  assign loaderBus.wdata = loadData;

  fetchUnit uFetch (.clk, .rst, .bus(fetchBus.master), .instrValid, .instr, .instrPc,
                    .take, .redirect, .target, .halted);

  execUnit uExec (.clk, .rst, .bus(dataBus.master), .instrValid, .instr, .instrPc,
                  .take, .redirect, .target, .halted, .commitValid, .commitAddr, .commitData);

  memArbiter uArb (.clk, .rst, .loader(loaderBus.slave), .data(dataBus.slave),
                   .fetch(fetchBus.slave), .memWe, .memAddr, .memWdata, .memRdata);

  unifiedMem uMem (.clk, .memWe, .memAddr, .memWdata, .memRdata);

  assign pc  = instrPc;  // Instruction in execute
  assign hlt = halted;

endmodule

// ==== tb/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

  localparam int   progLen     = 32;
  localparam int   commitLen   = 18;
  localparam int   resetCycles = 4;
  localparam wordT haltPc      = 16'h001F;
  localparam int   cycleLimit  = 20 * progLen + progLen + resetCycles;  // Run plus load

  //////////////////////////////
  // Program and expected commits
  //////////////////////////////
  localparam wordT progTable [progLen] = '{
    16'hB134, 16'hA112,  // R1 = 0x1234
    16'hB2F0,            // R2 = 0xFFF0 sign extended
    16'hB37F, 16'hA37F,  // R3 = 0x7F7F
    16'h0412, 16'h1512,  // ADD wraps then SUB
    16'h2612, 16'h3712,  // AND, NOR
    16'h4814, 16'h5924,  // SLL 4, SRL 4
    16'h6A22,            // SRA 2 keeps sign
    16'hBB40,            // R11 = base 0x40
    16'h91B3, 16'h93BE,  // SW +3, SW -2
    16'h8CB3, 16'h8DBE,  // LW back
    16'h1EC1,            // SUB to zero sets Z
    16'hC001,            // NEQ falls through
    16'hC201, 16'hBF55,  // EQ taken over skipped LLB
    16'h1E21,            // Negative SUB sets N
    16'hC601, 16'hBF66,  // LT taken
    16'h0F33,            // ADD overflow sets V
    16'hCC01, 16'hBF77,  // OVFL taken
    16'hCE02, 16'hBE11, 16'hBF22,  // UNCOND over two
    16'h0011,            // Write to R0
    16'hF000             // HLT at 0x1F
  };

  // Register in the top nibble and value below
  localparam logic [19:0] expCommit [commitLen] = '{
    20'h1_0034, 20'h1_1234, 20'h2_FFF0, 20'h3_007F, 20'h3_7F7F,
    20'h4_1224, 20'h5_1244, 20'h6_1230, 20'h7_000B, 20'h8_2340,
    20'h9_0FFF, 20'hA_FFFC, 20'hB_0040, 20'hC_1234, 20'hD_7F7F,
    20'hE_0000, 20'hE_EDBC, 20'hF_FEFE
  };

  logic    clk;
  logic    rst;
  logic    loadEn;
  wordT    loadAddr;
  wordT    loadData;
  logic    hlt;
  wordT    pc;
  logic    commitValid;
  regAddrT commitAddr;
  wordT    commitData;
  int      cycleCount = 0;
  int      idx;

  cpuTop DUT (.clk, .rst, .loadEn, .loadAddr, .loadData, .hlt, .pc,
              .commitValid, .commitAddr, .commitData);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Compare and stop helpers
  //////////////////////////////
  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Stopping on first error");
  endtask

  task automatic checkReg(input string name, input regAddrT expected, input regAddrT actual);
    if (actual !== expected)
      stopRun($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkWord(input string name, input wordT expected, input wordT actual);
    if (actual !== expected)
      stopRun($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      stopRun($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
  endtask

  // Guards against a program that never halts
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
      stopRun($sformatf("Timeout after %0d cycles without reaching halt", cycleLimit));
  end

  // Outputs quiet through reset and the first cycle after it
  initial begin
    @(posedge clk);
    @(negedge clk);
    while (rst) begin
      checkBit("hlt", 1'b0, hlt);
      checkBit("commitValid", 1'b0, commitValid);
      @(negedge clk);
    end
    checkBit("hlt", 1'b0, hlt);
    checkBit("commitValid", 1'b0, commitValid);
  end

  //////////////////////////////
  // Load then follow commits
  //////////////////////////////
  initial begin
    rst      = 1'b1;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    // Loader outranks fetch so words past reset only stall it
    for (int i = 0; i < progLen; i++) begin
      @(posedge clk);
      loadEn   <= 1'b1;
      loadAddr <= wordT'(i);
      loadData <= progTable[i];
      if (i == resetCycles - 1)
        rst <= 1'b0;  // Seen high on four edges
    end
    @(posedge clk);
    loadEn <= 1'b0;

    idx = 0;
    while (idx < commitLen) begin
      @(negedge clk);
      if (commitValid) begin
        checkReg("commitAddr", expCommit[idx][19:16], commitAddr);
        checkWord("commitData", expCommit[idx][15:0], commitData);
        idx++;
      end else if (hlt) begin
        stopRun($sformatf("Halted after only %0d of %0d commits", idx, commitLen));
      end
    end

    // R0 write and HLT still ahead
    @(negedge clk);
    while (!hlt) begin
      if (commitValid)
        stopRun("Unexpected commit between the last expected one and halt");
      @(negedge clk);
    end
    checkWord("pc", haltPc, pc);
    repeat (10) begin
      @(negedge clk);
      checkBit("hlt", 1'b1, hlt);
      checkWord("pc", haltPc, pc);
      if (commitValid)
        stopRun("Commit seen after the processor halted");
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/cpuPkg.sv
verilog/memBusIf.sv
verilog/unifiedMem.sv
verilog/memArbiter.sv
verilog/fetchUnit.sv
verilog/regFile.sv
verilog/aluFlags.sv
verilog/execUnit.sv
verilog/cpuTop.sv
tb/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cpuTb -f filelist.f -o cpuSim

./obj_dir/cpuSim 2>&1 | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
